// File: design/ram_geom_pkg.sv
`default_nettype none

package ram_geom_pkg;

    ////////////////////
    // Counter RAM geometry

    // One counter per port and class pair
    localparam int ADDR_W = 5;

    // Packet count above byte count
    localparam int DATA_W = 32;

    // Cycles from memre to valid memrdd
    localparam int RD_LATENCY = 2;

    typedef logic [ADDR_W-1:0] ram_addr_t;
    typedef logic [DATA_W-1:0] ram_word_t;

endpackage

`default_nettype wire

// File: design/stat_fmt_pkg.sv
`default_nettype none

package stat_fmt_pkg;

    ////////////////////
    // Event fields

    localparam int PORT_W  = 3;
    localparam int CLASS_W = 2;
    localparam int LEN_W   = 14;

    ////////////////////
    // Counter word fields

    localparam int PKT_CNT_W  = 8;
    localparam int BYTE_CNT_W = 24;

    typedef logic [PORT_W-1:0]     port_id_t;
    typedef logic [CLASS_W-1:0]    class_id_t;
    typedef logic [LEN_W-1:0]      pkt_len_t;
    typedef logic [PKT_CNT_W-1:0]  pkt_cnt_t;
    typedef logic [BYTE_CNT_W-1:0] byte_cnt_t;

endpackage

`default_nettype wire

// File: design/counter_ram.sv
`timescale 1ns/1ps
`default_nettype none

module counter_ram
(
    input  wire logic                    clk,
    input  wire logic                    memwe,
    input  wire logic                    memre,
    input  wire ram_geom_pkg::ram_addr_t memwa,
    input  wire ram_geom_pkg::ram_addr_t memra,
    input  wire ram_geom_pkg::ram_word_t memwrd,
    output ram_geom_pkg::ram_word_t      memrdd
);

    import ram_geom_pkg::*;

    // Register file, one word per counter
    ram_word_t mem [2**ADDR_W];
    ram_addr_t ra_q;

    ////////////////////
    // Write port

    always_ff @(posedge clk)
    begin
        if (memwe)
            mem[memwa] <= memwrd;
    end

    ////////////////////
    // Read port

    // Address stage, then data stage
    always_ff @(posedge clk)
    begin
        if (memre)
            ra_q <= memra;
        memrdd <= mem[ra_q];
    end

endmodule

`default_nettype wire

// File: design/host_access_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module host_access_ctrl
(
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  host_req,
    input  wire logic                  host_we,
    input  wire ram_geom_pkg::ram_addr_t host_addr,
    input  wire ram_geom_pkg::ram_word_t host_wdata,
    output logic                       host_busy,
    output logic                       host_done,
    output ram_geom_pkg::ram_word_t    host_rdata,
    output logic                       upen,
    output logic                       upws,
    output logic                       uprs,
    output ram_geom_pkg::ram_addr_t    upa,
    output ram_geom_pkg::ram_word_t    updi,
    input  wire ram_geom_pkg::ram_word_t updo,
    input  wire logic                  uprdy
);

    import ram_geom_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_STROBE, ST_WAIT} host_state_t;

    host_state_t state;
    logic        we_q;
    ram_addr_t   addr_q;
    ram_word_t   wdata_q;

    ////////////////////
    // Request FSM

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= ST_IDLE;
            host_done <= 1'b0;
        end
        else
        begin
            // Done pulse trails uprdy by one cycle
            host_done <= 1'b0;
            case (state)
                ST_IDLE:
                    if (host_req)
                        state <= ST_STROBE;
                // Strobe goes out for exactly one cycle
                ST_STROBE:
                    state <= ST_WAIT;
                ST_WAIT:
                    if (uprdy)
                    begin
                        state     <= ST_IDLE;
                        host_done <= 1'b1;
                    end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    // Request fields, taken only when idle so a busy request is ignored
    always_ff @(posedge clk)
    begin
        if (state == ST_IDLE && host_req)
        begin
            we_q    <= host_we;
            addr_q  <= host_addr;
            wdata_q <= host_wdata;
        end
        // Keep read data only for read accesses
        if (state == ST_WAIT && uprdy && !we_q)
            host_rdata <= updo;
    end

    ////////////////////
    // CPU port strobes

    assign host_busy = (state != ST_IDLE);
    assign upen      = (state != ST_IDLE);
    assign upws      = (state == ST_STROBE) && we_q;
    assign uprs      = (state == ST_STROBE) && !we_q;
    assign upa       = addr_q;
    assign updi      = wdata_q;

endmodule

`default_nettype wire

// File: design/stat_update_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module stat_update_pipe
(
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     event_valid,
    input  wire stat_fmt_pkg::port_id_t   event_port,
    input  wire stat_fmt_pkg::class_id_t  event_class,
    input  wire stat_fmt_pkg::pkt_len_t   event_len,
    output logic                          eng_re,
    output ram_geom_pkg::ram_addr_t       eng_ra,
    input  wire ram_geom_pkg::ram_word_t  eng_rdd,
    output logic                          eng_we,
    output ram_geom_pkg::ram_addr_t       eng_wa,
    output ram_geom_pkg::ram_word_t       eng_wrd
);

    import ram_geom_pkg::*;
    import stat_fmt_pkg::*;

    // Stage 1 issues the read, stage 3 sees its data
    logic      s1_valid;
    logic      s2_valid;
    logic      s3_valid;
    ram_addr_t s1_addr;
    ram_addr_t s2_addr;
    ram_addr_t s3_addr;
    pkt_len_t  s1_len;
    pkt_len_t  s2_len;
    pkt_len_t  s3_len;

    // Last write, for the read that was taken before it landed
    logic      pw_valid;
    ram_addr_t pw_addr;
    ram_word_t pw_data;

    ram_word_t             rd_word;
    pkt_cnt_t              pkt_old;
    pkt_cnt_t              pkt_new;
    byte_cnt_t             byte_old;
    byte_cnt_t             byte_new;
    logic [BYTE_CNT_W:0]   byte_sum;

    ////////////////////
    // Event shift

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
            pw_valid <= 1'b0;
        end
        else
        begin
            s1_valid <= event_valid;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
            pw_valid <= s3_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        // Port id sits above class id
        s1_addr <= {event_port, event_class};
        s1_len  <= event_len;
        s2_addr <= s1_addr;
        s2_len  <= s1_len;
        s3_addr <= s2_addr;
        s3_len  <= s2_len;
        pw_addr <= s3_addr;
        pw_data <= eng_wrd;
    end

    ////////////////////
    // Saturating update

    always_comb
    begin
        // Previous write is newer than what the RAM returned
        if (pw_valid && pw_addr == s3_addr)
            rd_word = pw_data;
        else
            rd_word = eng_rdd;

        pkt_old  = rd_word[DATA_W-1:BYTE_CNT_W];
        byte_old = rd_word[BYTE_CNT_W-1:0];

        // Packet field sticks at all ones
        if (pkt_old == '1)
            pkt_new = pkt_old;
        else
            pkt_new = pkt_old + 1'b1;

        // Carry out of the byte field means clamp
        byte_sum = {1'b0, byte_old} + (BYTE_CNT_W+1)'(s3_len);
        if (byte_sum[BYTE_CNT_W])
            byte_new = '1;
        else
            byte_new = byte_sum[BYTE_CNT_W-1:0];
    end

    assign eng_re  = s1_valid;
    assign eng_ra  = s1_addr;
    assign eng_we  = s3_valid;
    assign eng_wa  = s3_addr;
    assign eng_wrd = {pkt_new, byte_new};

endmodule

`default_nettype wire

// File: design/ram_access_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module ram_access_arbiter
(
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    active,
    input  wire logic                    eng_re,
    input  wire ram_geom_pkg::ram_addr_t eng_ra,
    output ram_geom_pkg::ram_word_t      eng_rdd,
    input  wire logic                    eng_we,
    input  wire ram_geom_pkg::ram_addr_t eng_wa,
    input  wire ram_geom_pkg::ram_word_t eng_wrd,
    input  wire logic                    upen,
    input  wire ram_geom_pkg::ram_addr_t upa,
    input  wire logic                    upws,
    input  wire logic                    uprs,
    input  wire ram_geom_pkg::ram_word_t updi,
    output ram_geom_pkg::ram_word_t      updo,
    output logic                         uprdy,
    output logic                         memwe,
    output logic                         memre,
    output ram_geom_pkg::ram_addr_t      memwa,
    output ram_geom_pkg::ram_addr_t      memra,
    output ram_geom_pkg::ram_word_t      memwrd,
    input  wire ram_geom_pkg::ram_word_t memrdd
);

    import ram_geom_pkg::*;

    logic      engwr;
    logic      engrd;
    logic      upwr_lat;
    logic      uprd_lat;
    logic      upwr_ok;
    logic      uprd_ok;
    logic      rd_any;
    ram_addr_t rd_addr;
    logic      wr_conflict;

    // Collision flags and write data, aligned with the read latency
    logic [RD_LATENCY-1:0] same_stage;
    ram_word_t             wrd_dly [RD_LATENCY];
    // Grant delay, one stage past the read data
    logic [RD_LATENCY:0]   grant_dly;
    ram_word_t             rdd_q;

    ////////////////////
    // Grant logic

    // Engine ports count only while enabled
    assign engwr = eng_we && active;
    assign engrd = eng_re && active;

    assign upwr_ok = upwr_lat && (!engwr || eng_wa == upa);
    // Host read must not race an engine write to the same word
    assign uprd_ok = uprd_lat && (!engrd || eng_ra == upa) && !(engwr && eng_wa == upa);

    always_ff @(posedge clk)
    begin
        if (rst || !upen)
        begin
            upwr_lat <= 1'b0;
            uprd_lat <= 1'b0;
        end
        else
        begin
            if (upwr_ok)
                upwr_lat <= 1'b0;
            else if (upws)
                upwr_lat <= 1'b1;
            if (uprd_ok)
                uprd_lat <= 1'b0;
            else if (uprs)
                uprd_lat <= 1'b1;
        end
    end

    ////////////////////
    // RAM port mux

    // A granted host write lands on the engine's address anyway
    assign memwe  = engwr || upwr_ok;
    assign memwa  = upwr_ok ? upa : eng_wa;
    assign memwrd = upwr_ok ? updi : eng_wrd;

    assign rd_any  = engrd || uprd_ok;
    assign rd_addr = engrd ? eng_ra : upa;
    assign wr_conflict = memwe && (memwa == rd_addr);

    // Read skipped on collision, write data stands in
    assign memre = rd_any && !wr_conflict;
    assign memra = rd_addr;

    always_ff @(posedge clk)
    begin
        if (rst)
            same_stage <= '0;
        else
            same_stage <= {same_stage[RD_LATENCY-2:0], rd_any && wr_conflict};
    end

    always_ff @(posedge clk)
    begin
        wrd_dly[0] <= memwrd;
        for (int i = 1; i < RD_LATENCY; i++)
            wrd_dly[i] <= wrd_dly[i-1];
        rdd_q <= eng_rdd;
    end

    assign eng_rdd = same_stage[RD_LATENCY-1] ? wrd_dly[RD_LATENCY-1] : memrdd;

    ////////////////////
    // Host return path

    always_ff @(posedge clk)
    begin
        if (rst)
            grant_dly <= '0;
        else
            grant_dly <= {grant_dly[RD_LATENCY-1:0], upwr_ok || uprd_ok};
    end

    assign uprdy = grant_dly[RD_LATENCY];
    assign updo  = upen ? rdd_q : '0;

endmodule

`default_nettype wire

// File: design/stat_counter_top.sv
`timescale 1ns/1ps
`default_nettype none

module stat_counter_top
(
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     event_valid,
    input  wire stat_fmt_pkg::port_id_t   event_port,
    input  wire stat_fmt_pkg::class_id_t  event_class,
    input  wire stat_fmt_pkg::pkt_len_t   event_len,
    input  wire logic                     engine_enable,
    input  wire logic                     host_req,
    input  wire logic                     host_we,
    input  wire ram_geom_pkg::ram_addr_t  host_addr,
    input  wire ram_geom_pkg::ram_word_t  host_wdata,
    output logic                          host_busy,
    output logic                          host_done,
    output ram_geom_pkg::ram_word_t       host_rdata
);

    import ram_geom_pkg::*;

    // Engine side
    logic      eng_re;
    logic      eng_we;
    ram_addr_t eng_ra;
    ram_addr_t eng_wa;
    ram_word_t eng_rdd;
    ram_word_t eng_wrd;

    // CPU side
    logic      upen;
    logic      upws;
    logic      uprs;
    logic      uprdy;
    ram_addr_t upa;
    ram_word_t updi;
    ram_word_t updo;

    // RAM side
    logic      memwe;
    logic      memre;
    ram_addr_t memwa;
    ram_addr_t memra;
    ram_word_t memwrd;
    ram_word_t memrdd;

    ////////////////////
    // Blocks

    host_access_ctrl host_access_ctrl_i (.*);

    stat_update_pipe stat_update_pipe_i (.*);

    ram_access_arbiter ram_access_arbiter_i
    (
        .active (engine_enable),
        .*
    );

    counter_ram counter_ram_i (.*);

endmodule

`default_nettype wire

// File: test/stat_counter_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module stat_counter_assertions
(
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    rd_any,
    input  wire logic                    memwe,
    input  wire logic                    memre,
    input  wire ram_geom_pkg::ram_addr_t memwa,
    input  wire ram_geom_pkg::ram_addr_t memra,
    input  wire ram_geom_pkg::ram_word_t memwrd,
    input  wire ram_geom_pkg::ram_word_t eng_rdd,
    input  wire logic                    upen,
    input  wire logic                    uprdy
);

    import ram_geom_pkg::*;

    ////////////////////
    // RAM port

    // Same-address collision skips the RAM read, write data comes back instead
    collision_returns_write_data: assert property (
        @(posedge clk) disable iff (rst)
        $past(rd_any && memwe && memra == memwa, RD_LATENCY)
            |-> !$past(memre, RD_LATENCY) && eng_rdd == $past(memwrd, RD_LATENCY)
    ) else $error("read colliding with a write did not return the write data");

    ////////////////////
    // CPU port return

    uprdy_single_pulse: assert property (
        @(posedge clk) disable iff (rst)
        uprdy |=> !uprdy
    ) else $error("uprdy stayed high for more than one cycle");

    // Host holds upen until the access completes
    uprdy_inside_upen: assert property (
        @(posedge clk) disable iff (rst)
        uprdy |-> upen
    ) else $error("uprdy raised while upen was low");

endmodule

bind ram_access_arbiter stat_counter_assertions stat_counter_assertions_i
(
    .clk     (clk),
    .rst     (rst),
    .rd_any  (rd_any),
    .memwe   (memwe),
    .memre   (memre),
    .memwa   (memwa),
    .memra   (memra),
    .memwrd  (memwrd),
    .eng_rdd (eng_rdd),
    .upen    (upen),
    .uprdy   (uprdy)
);

`default_nettype wire

// File: test/tb_stat_counter.sv
`timescale 1ns/1ps
`default_nettype none

module tb_stat_counter;

    import ram_geom_pkg::*;
    import stat_fmt_pkg::*;

    logic      clk;
    logic      rst;
    logic      event_valid;
    port_id_t  event_port;
    class_id_t event_class;
    pkt_len_t  event_len;
    logic      engine_enable;
    logic      host_req;
    logic      host_we;
    ram_addr_t host_addr;
    ram_word_t host_wdata;
    logic      host_busy;
    logic      host_done;
    ram_word_t host_rdata;

    // Reference copy of every counter word
    ram_word_t   model [2**ADDR_W];
    logic [31:0] lcg_state;

    stat_counter_top stat_counter_top_i (.*);

    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;
    end

    ////////////////////
    // Helpers

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Packet field +1, byte field +len, both clamp at all ones
    function automatic ram_word_t apply_event(input ram_word_t word, input pkt_len_t len);
        int pkts;
        int bytes;
        pkts  = word[DATA_W-1:BYTE_CNT_W];
        bytes = word[BYTE_CNT_W-1:0];
        pkts  = pkts + 1;
        bytes = bytes + len;
        if (pkts > (1 << PKT_CNT_W) - 1)
            pkts = (1 << PKT_CNT_W) - 1;
        if (bytes > (1 << BYTE_CNT_W) - 1)
            bytes = (1 << BYTE_CNT_W) - 1;
        return {pkt_cnt_t'(pkts), byte_cnt_t'(bytes)};
    endfunction

    task automatic stop_run();
        $display("test failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_word(input ram_addr_t addr, input ram_word_t got, input ram_word_t exp);
        if (got !== exp)
        begin
            $display("error at %0t: counter %0d read %08h, expected %08h", $time, addr, got, exp);
            stop_run();
        end
    endtask

    task automatic start_request(input logic we, input ram_addr_t addr, input ram_word_t wdata);
        @(posedge clk);
        host_req   <= 1'b1;
        host_we    <= we;
        host_addr  <= addr;
        host_wdata <= wdata;
        @(posedge clk);
        host_req <= 1'b0;
    endtask

    // host_rdata is captured on the same edge that raises host_done
    task automatic wait_done();
        int waited;
        waited = 0;
        do
        begin
            @(negedge clk);
            waited++;
            if (waited > 200)
            begin
                $display("host access timed out, host_done never came at %0t", $time);
                stop_run();
            end
        end
        while (!host_done);
    endtask

    task automatic host_access(input logic we, input ram_addr_t addr, input ram_word_t wdata,
                               output ram_word_t rdata);
        start_request(we, addr, wdata);
        wait_done();
        rdata = host_rdata;
        if (we)
            model[addr] = wdata;
    endtask

    // Address is port id above class id
    task automatic send_event(input ram_addr_t addr, input pkt_len_t len);
        @(posedge clk);
        event_valid <= 1'b1;
        event_port  <= addr[ADDR_W-1:CLASS_W];
        event_class <= addr[CLASS_W-1:0];
        event_len   <= len;
        if (engine_enable)
            model[addr] = apply_event(model[addr], len);
    endtask

    task automatic idle_events();
        @(posedge clk);
        event_valid <= 1'b0;
    endtask

    // Write lands three cycles after the event, so a few idle cycles settle it
    task automatic drain();
        idle_events();
        repeat (5) @(posedge clk);
    endtask

    task automatic check_all();
        ram_word_t data;
        for (int a = 0; a < 2**ADDR_W; a++)
        begin
            host_access(1'b0, ram_addr_t'(a), '0, data);
            check_word(ram_addr_t'(a), data, model[a]);
        end
    endtask

    ////////////////////
    // Directed tests

    task automatic test_reset_and_clear();
        ram_word_t data;
        @(negedge clk);
        if (host_busy || host_done)
        begin
            $display("host_busy or host_done high after reset");
            stop_run();
        end
        for (int a = 0; a < 2**ADDR_W; a++)
            host_access(1'b1, ram_addr_t'(a), '0, data);
        check_all();
    endtask

    task automatic test_write_read_and_busy();
        ram_word_t data;
        start_request(1'b1, 5'd9, 32'h1234_5678);
        model[9] = 32'h1234_5678;
        @(negedge clk);
        if (!host_busy)
        begin
            $display("host_busy did not rise after a host request");
            stop_run();
        end
        // Second request while busy must be dropped
        start_request(1'b1, 5'd10, 32'h0bad_cafe);
        wait_done();
        repeat (3)
        begin
            @(negedge clk);
            if (host_busy)
            begin
                $display("a request given while busy started a second access");
                stop_run();
            end
        end
        host_access(1'b0, 5'd9, '0, data);
        check_word(5'd9, data, model[9]);
        host_access(1'b0, 5'd10, '0, data);
        check_word(5'd10, data, model[10]);
    endtask

    task automatic test_single_events();
        logic [31:0] rnd;
        repeat (24)
        begin
            rnd = lcg_next();
            send_event(rnd[28:24], rnd[21:8]);
            drain();
        end
        check_all();
    endtask

    task automatic test_bursts();
        logic [31:0] rnd;
        // Back to back on one counter, then two counters interleaved
        for (int i = 0; i < 8; i++)
        begin
            rnd = lcg_next();
            send_event(5'd7, rnd[21:8]);
        end
        for (int i = 0; i < 10; i++)
        begin
            rnd = lcg_next();
            send_event((i % 2) ? 5'd13 : 5'd12, rnd[21:8]);
        end
        drain();
        check_all();
    endtask

    task automatic test_saturation();
        ram_word_t data;
        host_access(1'b1, 5'd20, {8'hfd, 24'hff_f000}, data);
        repeat (5)
            send_event(5'd20, 14'h3fff);
        drain();
        host_access(1'b0, 5'd20, '0, data);
        check_word(5'd20, data, model[20]);
        check_word(5'd20, data, 32'hffff_ffff);
    endtask

    task automatic test_stream_and_disable();
        ram_word_t   data;
        logic [31:0] rnd;
        fork
            begin
                // Stream stays on ports 0 to 3
                repeat (150)
                begin
                    rnd = lcg_next();
                    if (rnd[31])
                        send_event({1'b0, rnd[27:24]}, rnd[21:8]);
                    else
                        idle_events();
                end
                idle_events();
            end
            for (int a = 16; a < 2**ADDR_W; a++)
            begin
                host_access(1'b0, ram_addr_t'(a), '0, data);
                check_word(ram_addr_t'(a), data, model[a]);
            end
        join
        drain();
        check_all();
        // Events with the engine off never reach the RAM
        @(posedge clk);
        engine_enable <= 1'b0;
        repeat (2) @(posedge clk);
        repeat (12)
        begin
            rnd = lcg_next();
            send_event(rnd[28:24], rnd[21:8]);
        end
        drain();
        engine_enable <= 1'b1;
        check_all();
    endtask

    initial
    begin
        lcg_state     = 32'hd91d69a8;
        rst           = 1'b1;
        event_valid   = 1'b0;
        event_port    = '0;
        event_class   = '0;
        event_len     = '0;
        engine_enable = 1'b1;
        host_req      = 1'b0;
        host_we       = 1'b0;
        host_addr     = '0;
        host_wdata    = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        test_reset_and_clear();
        test_write_read_and_busy();
        test_single_events();
        test_bursts();
        test_saturation();
        test_stream_and_disable();
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
design/ram_geom_pkg.sv
design/stat_fmt_pkg.sv
design/counter_ram.sv
design/host_access_ctrl.sv
design/stat_update_pipe.sv
design/ram_access_arbiter.sv
design/stat_counter_top.sv
test/stat_counter_assertions.sv
test/tb_stat_counter.sv

// File: run.sh
#!/bin/sh
# Build the statistics counter testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal --top-module tb_stat_counter \
    -f verilog.f -o tb_sim > build.log 2>&1 \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -q "test failed" sim.log && { echo "Simulation reported a failure"; exit 1; }
grep -q "test passed" sim.log || { echo "No result found in sim.log"; exit 1; }
exit 0
